// File: filelist.f
logic/udp_pkg.sv
logic/stream_pkg.sv
logic/udp_port_filter.sv
logic/udp_reply_header.sv
logic/payload_fifo.sv
logic/led_capture.sv
logic/udp_echo_top.sv
test/udp_echo_sva.sv
test/udp_echo_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := udp_echo_tb
RTL_TOP    := udp_echo_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/udp_echo_tb.sv
`default_nettype none

module udp_echo_tb
  import udp_pkg::*, stream_pkg::*;
();

  localparam udp_port_t ECHO_PORT      = 16'd1234;
  localparam ip_addr_t  LOCAL_IP       = {8'd192, 8'd168, 8'd1, 8'd128};
  localparam int        FIFO_DEPTH     = 16;
  localparam int        TOTAL_BYTES    = 1 + 7 + 20 + 9 + 4 + 40 + 33 + 17 + 25;
  localparam int        TIMEOUT_CYCLES = TOTAL_BYTES * 4 + 500;

  logic          clk;
  logic          rst = 1'b1;
  udp_hdr_t      rx_hdr = '0;
  logic          rx_hdr_valid = 1'b0;
  logic          rx_hdr_ready;
  payload_beat_t rx_data = '0;
  logic          rx_data_valid = 1'b0;
  logic          rx_data_ready;
  udp_hdr_t      tx_hdr;
  logic          tx_hdr_valid;
  logic          tx_hdr_ready = 1'b1;
  payload_beat_t tx_data;
  logic          tx_data_valid;
  logic          tx_data_ready = 1'b1;
  byte_t         led;

  udp_hdr_t      exp_hdr_q[$];
  payload_beat_t exp_beat_q[$];
  byte_t         exp_led;
  logic          stall_en = 1'b0;
  int            cycle_count;
  int unsigned   seed_dummy;
  int            hdr_errors = 0;
  int            beat_errors = 0;
  int            led_errors = 0;
  int            flag_errors = 0;

  udp_echo_top #(
    .ECHO_PORT (ECHO_PORT),
    .LOCAL_IP  (LOCAL_IP),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Transmit side sink, stalls at random while enabled
  always @(posedge clk)
  begin
    tx_hdr_ready  <= stall_en ? (($urandom % 3) == 0) : 1'b1;
    tx_data_ready <= stall_en ? (($urandom % 2) == 0) : 1'b1;
  end

  task automatic check_hdr(input udp_hdr_t got, input udp_hdr_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t tx_hdr got %h expected %h", $time, got, exp);
      hdr_errors++;
    end
  endtask

  task automatic check_beat(input payload_beat_t got, input payload_beat_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t tx_data got %h expected %h", $time, got, exp);
      beat_errors++;
    end
  endtask

  task automatic check_led(input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t led got %h expected %h", $time, got, exp);
      led_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      flag_errors++;
    end
  endtask

  // Every transmit transfer must match the oldest prediction
  always @(posedge clk)
  begin
    if (!rst && tx_hdr_valid && tx_hdr_ready)
    begin
      if (exp_hdr_q.size() == 0)
      begin
        $display("Unexpected tx header at time %0t with no reply pending", $time);
        hdr_errors++;
      end
      else
        check_hdr(tx_hdr, exp_hdr_q.pop_front());
    end
    if (!rst && tx_data_valid && tx_data_ready)
    begin
      if (exp_beat_q.size() == 0)
      begin
        $display("Unexpected tx payload byte at time %0t", $time);
        beat_errors++;
      end
      else
        check_beat(tx_data, exp_beat_q.pop_front());
    end
  end

  // Reply as an echo server answers: back to the sender from the echo port
  function automatic udp_hdr_t reply_for(input udp_hdr_t rx);
    udp_hdr_t r;
    r.src_ip   = LOCAL_IP;
    r.dst_ip   = rx.src_ip;
    r.src_port = rx.dst_port;
    r.dst_port = rx.src_port;
    r.length   = rx.length;
    r.ttl      = 8'd64;
    r.checksum = 16'h0000;
    return r;
  endfunction

  task automatic send_datagram(input udp_port_t dst_port, input int len);
    udp_hdr_t      hdr;
    payload_beat_t beat;
    logic          echo;
    echo         = (dst_port == ECHO_PORT);
    hdr.src_ip   = ip_addr_t'($urandom);
    hdr.dst_ip   = LOCAL_IP;
    hdr.src_port = udp_port_t'($urandom);
    hdr.dst_port = dst_port;
    hdr.length   = udp_len_t'(len + 8);
    hdr.ttl      = ttl_t'($urandom);
    hdr.checksum = csum_t'($urandom);
    if (echo)
      exp_hdr_q.push_back(reply_for(hdr));
    rx_hdr       <= hdr;
    rx_hdr_valid <= 1'b1;
    do
      @(posedge clk);
    while (!rx_hdr_ready);
    rx_hdr_valid <= 1'b0;
    for (int i = 0; i < len; i++)
    begin
      beat.data = byte_t'($urandom);
      beat.last = (i == len - 1);
      if (echo)
        exp_beat_q.push_back(beat);
      if (echo && i == 0)
        exp_led = beat.data;
      rx_data       <= beat;
      rx_data_valid <= 1'b1;
      do
        @(posedge clk);
      while (!rx_data_ready);
    end
    rx_data_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    do
      @(posedge clk);
    while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0);
    @(posedge clk);
  endtask

  task automatic test_reset();
    @(posedge clk);
    // Matching port on the bus, header not offered
    rx_hdr.dst_port <= ECHO_PORT;
    repeat (15) @(posedge clk);
    check_flag("rx_hdr_ready", rx_hdr_ready, 1'b0);
    check_flag("rx_data_ready", rx_data_ready, 1'b0);
    rst <= 1'b0;
    @(posedge clk);
    check_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
    check_flag("tx_data_valid", tx_data_valid, 1'b0);
    check_led(led, 8'h00);
  endtask

  task automatic test_echo();
    send_datagram(ECHO_PORT, 1);
    wait_drain();
    check_led(led, exp_led);
    send_datagram(ECHO_PORT, 7);
    wait_drain();
    check_led(led, exp_led);
    send_datagram(ECHO_PORT, 20);
    wait_drain();
    check_led(led, exp_led);
  endtask

  task automatic test_drop();
    udp_port_t port;
    port = udp_port_t'($urandom);
    if (port == ECHO_PORT)
      port = port + 16'd1;
    send_datagram(port, 9);
    // Give any wrongly forwarded byte time to show up
    repeat (6) @(posedge clk);
    check_led(led, exp_led);
    send_datagram(ECHO_PORT, 4);
    wait_drain();
    check_led(led, exp_led);
  endtask

  task automatic test_backpressure();
    stall_en <= 1'b1;
    send_datagram(ECHO_PORT, 40);
    send_datagram(ECHO_PORT, 33);
    send_datagram(ECHO_PORT, 17);
    send_datagram(ECHO_PORT, 25);
    wait_drain();
    stall_en <= 1'b0;
    check_led(led, exp_led);
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    seed_dummy = $urandom(32'h844c_9d3a);
    test_reset();
    test_echo();
    test_drop();
    test_backpressure();
    $display("Errors: header %0d, payload %0d, led %0d, reset %0d",
             hdr_errors, beat_errors, led_errors, flag_errors);
    if (hdr_errors + beat_errors + led_errors + flag_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/udp_echo_sva.sv
`default_nettype none

module udp_echo_sva
  import udp_pkg::*, stream_pkg::*;
(
  input wire logic          clk,
  input wire logic          rst,
  input wire udp_hdr_t      rx_hdr,
  input wire logic          rx_hdr_valid,
  input wire logic          rx_hdr_ready,
  input wire payload_beat_t rx_data,
  input wire logic          rx_data_valid,
  input wire logic          rx_data_ready,
  input wire udp_hdr_t      tx_hdr,
  input wire logic          tx_hdr_valid,
  input wire logic          tx_hdr_ready,
  input wire payload_beat_t tx_data,
  input wire logic          tx_data_valid,
  input wire logic          tx_data_ready
);

  // Every source holds valid and data until the transfer
  rx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    rx_hdr_valid && !rx_hdr_ready |=> rx_hdr_valid && $stable(rx_hdr))
    else $error("rx_hdr withdrawn or changed before its transfer");

  rx_data_hold: assert property (@(posedge clk) disable iff (rst)
    rx_data_valid && !rx_data_ready |=> rx_data_valid && $stable(rx_data))
    else $error("rx_data withdrawn or changed before its transfer");

  tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
    else $error("tx_hdr withdrawn or changed before its transfer");

  tx_data_hold: assert property (@(posedge clk) disable iff (rst)
    tx_data_valid && !tx_data_ready |=> tx_data_valid && $stable(tx_data))
    else $error("tx_data withdrawn or changed before its transfer");

  // Nothing offered on the transmit side while in reset
  tx_quiet_in_reset: assert property (@(posedge clk)
    rst |=> !tx_hdr_valid && !tx_data_valid)
    else $error("tx valid high during reset");

endmodule

bind udp_echo_top udp_echo_sva u_sva (.*);

`default_nettype wire

// File: logic/udp_echo_top.sv
`default_nettype none

module udp_echo_top
  import udp_pkg::*, stream_pkg::*;
#(
  parameter udp_port_t ECHO_PORT  = 16'd1234,
  parameter ip_addr_t  LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
  parameter int        FIFO_DEPTH = 16
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire udp_hdr_t      rx_hdr,
  input  wire logic          rx_hdr_valid,
  output logic               rx_hdr_ready,
  input  wire payload_beat_t rx_data,
  input  wire logic          rx_data_valid,
  output logic               rx_data_ready,
  output udp_hdr_t           tx_hdr,
  output logic               tx_hdr_valid,
  input  wire logic          tx_hdr_ready,
  output payload_beat_t      tx_data,
  output logic               tx_data_valid,
  input  wire logic          tx_data_ready,
  output byte_t              led
);

  // Filter to header builder
  udp_hdr_t      match_hdr;
  logic          match_hdr_valid;
  logic          match_hdr_ready;

  // Filter to payload FIFO
  payload_beat_t fwd_data;
  logic          fwd_valid;
  logic          fwd_ready;

  udp_port_filter #(.ECHO_PORT(ECHO_PORT)) u_filter (
    .clk            (clk),
    .rst            (rst),
    .rx_hdr         (rx_hdr),
    .rx_hdr_valid   (rx_hdr_valid),
    .rx_hdr_ready   (rx_hdr_ready),
    .rx_data        (rx_data),
    .rx_data_valid  (rx_data_valid),
    .rx_data_ready  (rx_data_ready),
    .match_hdr      (match_hdr),
    .match_hdr_valid(match_hdr_valid),
    .match_hdr_ready(match_hdr_ready),
    .fwd_data       (fwd_data),
    .fwd_valid      (fwd_valid),
    .fwd_ready      (fwd_ready)
  );

  udp_reply_header #(.LOCAL_IP(LOCAL_IP)) u_reply (
    .clk            (clk),
    .rst            (rst),
    .match_hdr      (match_hdr),
    .match_hdr_valid(match_hdr_valid),
    .match_hdr_ready(match_hdr_ready),
    .tx_hdr         (tx_hdr),
    .tx_hdr_valid   (tx_hdr_valid),
    .tx_hdr_ready   (tx_hdr_ready)
  );

  payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_data (fwd_data),
    .wr_valid(fwd_valid),
    .wr_ready(fwd_ready),
    .rd_data (tx_data),
    .rd_valid(tx_data_valid),
    .rd_ready(tx_data_ready)
  );

  // Watches the outgoing payload only
  led_capture u_led (
    .clk          (clk),
    .rst          (rst),
    .tx_data      (tx_data),
    .tx_data_valid(tx_data_valid),
    .tx_data_ready(tx_data_ready),
    .led          (led)
  );

endmodule

`default_nettype wire

// File: logic/led_capture.sv
`default_nettype none

module led_capture
  import stream_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire payload_beat_t tx_data,
  input  wire logic          tx_data_valid,
  input  wire logic          tx_data_ready,
  output byte_t              led
);

  logic first_q;
  logic xfer;

  assign xfer = tx_data_valid && tx_data_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led     <= '0;
      first_q <= 1'b1;
    end
    else if (xfer)
    begin
      if (first_q)
      begin
        led     <= tx_data.data;
        first_q <= 1'b0;
      end
      // Next beat opens a new datagram, even after a one-byte one
      if (tx_data.last)
        first_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/payload_fifo.sv
`default_nettype none

module payload_fifo
  import stream_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire payload_beat_t wr_data,
  input  wire logic          wr_valid,
  output logic               wr_ready,
  output payload_beat_t      rd_data,
  output logic               rd_valid,
  input  wire logic          rd_ready
);

  localparam int AW = $clog2(FIFO_DEPTH);

  typedef logic [AW-1:0] ptr_t;
  typedef logic [AW:0]   count_t;

  localparam count_t FULL_COUNT = count_t'(FIFO_DEPTH);

  payload_beat_t mem [FIFO_DEPTH];
  ptr_t          wr_ptr_q;
  ptr_t          rd_ptr_q;
  count_t        count_q;
  logic          wr_en;
  logic          rd_en;

  assign wr_ready = (count_q != FULL_COUNT);
  assign rd_valid = (count_q != '0);
  assign rd_data  = mem[rd_ptr_q];

  assign wr_en = wr_valid && wr_ready;
  assign rd_en = rd_valid && rd_ready;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr_q] <= wr_data;
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/udp_reply_header.sv
`default_nettype none

module udp_reply_header
  import udp_pkg::*;
#(
  parameter ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128}
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire udp_hdr_t match_hdr,
  input  wire logic     match_hdr_valid,
  output logic          match_hdr_ready,
  output udp_hdr_t      tx_hdr,
  output logic          tx_hdr_valid,
  input  wire logic     tx_hdr_ready
);

  udp_hdr_t reply;
  udp_hdr_t hdr_q;
  logic     full_q;

  // Reply goes back to the sender from the echo port
  always_comb
  begin
    reply.src_ip   = LOCAL_IP;
    reply.dst_ip   = match_hdr.src_ip;
    reply.src_port = match_hdr.dst_port;
    reply.dst_port = match_hdr.src_port;
    reply.length   = match_hdr.length;
    reply.ttl      = REPLY_TTL;
    reply.checksum = '0;
  end

  assign match_hdr_ready = !full_q || tx_hdr_ready;
  assign tx_hdr          = hdr_q;
  assign tx_hdr_valid    = full_q;

  always_ff @(posedge clk)
  begin
    if (match_hdr_valid && match_hdr_ready)
      hdr_q <= reply;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      full_q <= 1'b0;
    else if (match_hdr_valid && match_hdr_ready)
      full_q <= 1'b1;
    else if (tx_hdr_ready)
      full_q <= 1'b0;
  end

endmodule

`default_nettype wire

// File: logic/udp_port_filter.sv
`default_nettype none

module udp_port_filter
  import udp_pkg::*, stream_pkg::*;
#(
  parameter udp_port_t ECHO_PORT = 16'd1234
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire udp_hdr_t      rx_hdr,
  input  wire logic          rx_hdr_valid,
  output logic               rx_hdr_ready,
  input  wire payload_beat_t rx_data,
  input  wire logic          rx_data_valid,
  output logic               rx_data_ready,
  output udp_hdr_t           match_hdr,
  output logic               match_hdr_valid,
  input  wire logic          match_hdr_ready,
  output payload_beat_t      fwd_data,
  output logic               fwd_valid,
  input  wire logic          fwd_ready
);

  typedef enum logic [1:0] {IDLE, FORWARD, DROP} state_t;

  state_t state_q;
  state_t state_d;
  logic   run_q;
  logic   hdr_match;
  logic   hdr_xfer;
  logic   last_xfer;

  assign hdr_match = (rx_hdr.dst_port == ECHO_PORT);

  // Matched headers go straight to the header builder
  assign match_hdr       = rx_hdr;
  assign match_hdr_valid = (state_q == IDLE) && run_q && rx_hdr_valid && hdr_match;
  assign rx_hdr_ready    = (state_q == IDLE) && (hdr_match ? (run_q && match_hdr_ready) : 1'b1);
  assign hdr_xfer        = rx_hdr_valid && rx_hdr_ready;

  assign fwd_data  = rx_data;
  assign fwd_valid = (state_q == FORWARD) && rx_data_valid;

  always_comb
  begin
    case (state_q)
      FORWARD: rx_data_ready = fwd_ready;
      DROP:    rx_data_ready = 1'b1;
      default: rx_data_ready = 1'b0;
    endcase
  end

  assign last_xfer = rx_data_valid && rx_data_ready && rx_data.last;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (hdr_xfer)
          state_d = hdr_match ? FORWARD : DROP;
      end
      FORWARD, DROP:
      begin
        if (last_xfer)
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      run_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Matched headers held off until the first cycle after reset
      run_q   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/stream_pkg.sv
`default_nettype none

package stream_pkg;

  typedef logic [7:0] byte_t;

  // One payload byte, last marks the end of a datagram
  typedef struct packed {
    byte_t data;
    logic  last;
  } payload_beat_t;

endpackage

`default_nettype wire

// File: logic/udp_pkg.sv
`default_nettype none

package udp_pkg;

  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;
  typedef logic [7:0]  ttl_t;
  typedef logic [15:0] csum_t;

  // Header fields that cross the echo stage
  typedef struct packed {
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;
    ttl_t      ttl;
    csum_t     checksum;
  } udp_hdr_t;

  // TTL placed in every reply
  localparam ttl_t REPLY_TTL = 8'd64;

endpackage

`default_nettype wire
